// File: vlog.f
+incdir+design
design/clint_pkg.sv
design/clint_timer.sv
design/clint_addr_stage.sv
design/clint_delay_lfsr.sv
design/clint_read_stage.sv
design/clint_top.sv
tb/tb_clock_gen.sv
tb/clint_checker.sv
tb/tb_clint.sv

// File: tb/tb_clint.sv
// testbench top for clint_top; random reads from a fixed seed
// the run is cut off at 20 cycles per read
`timescale 1ns/1ps
`default_nettype none

`include "clint_cfg.svh"

module tb_clint;

	localparam logic [31:0] SEED        = 32'hfc79_f51b;
	localparam logic [31:0] WIN_BASE    = `CLINT_BASE;
	localparam int          N_PAIRS     = 60;
	localparam int          N_ERR       = 40;
	localparam int          N_MIX       = 200;
	localparam int          N_RST_PAIRS = 20;
	localparam int          TOTAL_READS = 1 + 2 * N_PAIRS + N_ERR + N_MIX + 1 + 2 * N_RST_PAIRS;
	localparam int          CYCLE_LIMIT = TOTAL_READS * 20;

	logic        clock;
	logic        rstn;
	logic        rst_req;
	logic [31:0] addr;
	logic        addr_valid;
	logic        addr_ready;
	logic [31:0] r_data;
	logic [1:0]  r_resp;
	logic        r_valid;
	logic        r_ready;
	logic        bp_on;
	int          err_count;
	int          beat_count;
	int          inflight;
	int          tb_errors;
	int          mark_beats;
	int          mark_errs;
	int          cycle_count;

	tb_clock_gen u_clk (
		.rst_req_i (rst_req),
		.clock_o   (clock),
		.rstn_o    (rstn)
	);

	clint_top u_dut (
		.clock_i        (clock),
		.rstn_i         (rstn),
		.addr_r_addr_i  (addr),
		.addr_r_valid_i (addr_valid),
		.addr_r_ready_o (addr_ready),
		.r_data_o       (r_data),
		.r_resp_o       (r_resp),
		.r_valid_o      (r_valid),
		.r_ready_i      (r_ready)
	);

	clint_checker u_chk (
		.clock_i      (clock),
		.rstn_i       (rstn),
		.addr_i       (addr),
		.addr_valid_i (addr_valid),
		.addr_ready_i (addr_ready),
		.r_data_i     (r_data),
		.r_resp_i     (r_resp),
		.r_valid_i    (r_valid),
		.r_ready_i    (r_ready),
		.err_count_o  (err_count),
		.beat_count_o (beat_count),
		.inflight_o   (inflight)
	);

	function automatic logic [31:0] lo_addr();
		return {WIN_BASE[31:16], `CLINT_MTIME_LO_OFS};
	endfunction

	function automatic logic [31:0] hi_addr();
		return {WIN_BASE[31:16], `CLINT_MTIME_HI_OFS};
	endfunction

	// any window offset except the two mtime words
	function automatic logic [31:0] bad_addr();
		logic [15:0] ofs;
		ofs = 16'($urandom);
		while (ofs == `CLINT_MTIME_LO_OFS || ofs == `CLINT_MTIME_HI_OFS) begin
			ofs = 16'($urandom);
		end
		return {WIN_BASE[31:16], ofs};
	endfunction

	function automatic logic [31:0] out_addr();
		logic [15:0] top;
		top = 16'($urandom);
		while (top == WIN_BASE[31:16]) begin
			top = 16'($urandom);
		end
		return {top, 16'($urandom)};
	endfunction

	// mostly mtime words, now and then an error address
	function automatic logic [31:0] mix_addr();
		int pick;
		pick = $urandom % 8;
		if (pick < 3) begin
			return lo_addr();
		end
		if (pick < 6) begin
			return hi_addr();
		end
		if (pick == 6) begin
			return bad_addr();
		end
		return out_addr();
	endfunction

	// called 1 ns after a rising edge, returns 1 ns after the transfer edge
	task automatic issue_read(input logic [31:0] a);
		addr       = a;
		addr_valid = 1'b1;
		@(negedge clock);
		while (addr_ready !== 1'b1) begin
			@(negedge clock);
		end
		@(posedge clock);
		#1;
		addr_valid = 1'b0;
	endtask

	task automatic idle_gap(input int max_gap);
		repeat ($urandom % (max_gap + 1)) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic drain_reads();
		bp_on = 1'b0;
		@(posedge clock);
		#1;
		while (inflight != 0) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic pulse_reset();
		rst_req = 1'b1;
		repeat (2) @(posedge clock);
		#1;
		rst_req = 1'b0;
	endtask

	task automatic finish_test(input string name, input int reads);
		int beats;
		int errs;
		drain_reads();
		beats = beat_count - mark_beats;
		if (beats != reads) begin
			$display("error: test %s issued %0d reads but saw %0d responses", name, reads,
				beats);
			tb_errors++;
		end
		errs = err_count + tb_errors - mark_errs;
		$display("test %s finished: %0d reads, %0d errors", name, reads, errs);
		mark_beats = beat_count;
		mark_errs  = err_count + tb_errors;
	endtask

	// random back-pressure on the read-data channel
	always @(posedge clock) begin
		#1;
		if (bp_on) begin
			r_ready = ($urandom % 3) != 0;
		end else begin
			r_ready = 1'b1;
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: the tests did not end within %0d cycles", CYCLE_LIMIT);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		addr       = 32'd0;
		addr_valid = 1'b0;
		r_ready    = 1'b0;
		rst_req    = 1'b0;
		bp_on      = 1'b0;
		tb_errors  = 0;
		mark_beats = 0;
		mark_errs  = 0;
		void'($urandom(SEED));
		repeat (3) @(posedge clock);
		#1;

		// latch is still zero before any low read
		issue_read(hi_addr());
		finish_test("hi_before_lo", 1);

		// long enough to cross the 32-bit carry
		for (int i = 0; i < N_PAIRS; i++) begin
			idle_gap(2);
			issue_read(lo_addr());
			idle_gap(2);
			issue_read(hi_addr());
		end
		finish_test("lo_hi_pairs", 2 * N_PAIRS);

		for (int i = 0; i < N_ERR; i++) begin
			idle_gap(1);
			if (i % 2 == 0) begin
				issue_read(bad_addr());
			end else begin
				issue_read(out_addr());
			end
		end
		finish_test("error_decode", N_ERR);

		bp_on = 1'b1;
		for (int i = 0; i < N_MIX; i++) begin
			idle_gap(3);
			issue_read(mix_addr());
		end
		finish_test("backpressure_mix", N_MIX);

		// second reset, mtime and latch start over
		pulse_reset();
		issue_read(hi_addr());
		for (int i = 0; i < N_RST_PAIRS; i++) begin
			idle_gap(2);
			issue_read(lo_addr());
			issue_read(hi_addr());
		end
		finish_test("reset_restart", 1 + 2 * N_RST_PAIRS);

		$display("summary: 5 tests, %0d responses checked, %0d errors", beat_count,
			err_count + tb_errors);
		if (err_count + tb_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/clint_checker.sv
// cycle model of mtime, the high latch and the two-entry read pipeline
// samples at the falling edge; each step models the rising edge that follows
`timescale 1ns/1ps
`default_nettype none

`include "clint_cfg.svh"

module clint_checker
	import clint_pkg::*;
(
	input  wire logic        clock_i,
	input  wire logic        rstn_i,
	input  wire logic [31:0] addr_i,
	input  wire logic        addr_valid_i,
	input  wire logic        addr_ready_i,
	input  wire logic [31:0] r_data_i,
	input  wire logic [1:0]  r_resp_i,
	input  wire logic        r_valid_i,
	input  wire logic        r_ready_i,
	output int               err_count_o,
	output int               beat_count_o,
	output int               inflight_o
);

	localparam logic [31:0] WIN_BASE = `CLINT_BASE;

	logic [63:0] mtime_m;
	logic [31:0] hi_m;
	logic        addr_full;
	clint_sel_e  addr_sel;
	logic        slot_full;
	logic        rst_edge;
	logic        hold;
	logic [31:0] hold_data;
	logic [1:0]  hold_resp;
	logic [31:0] exp_data_q[$];
	logic [1:0]  exp_resp_q[$];
	int          err_cnt;
	int          beat_cnt;
	int          inflight;

	assign err_count_o  = err_cnt;
	assign beat_count_o = beat_cnt;
	assign inflight_o   = inflight;

	function automatic clint_sel_e decode_addr(input logic [31:0] addr);
		if (addr[31:16] != WIN_BASE[31:16]) begin
			return SEL_OUT;
		end
		if (addr[15:0] == `CLINT_MTIME_LO_OFS) begin
			return SEL_LO;
		end
		if (addr[15:0] == `CLINT_MTIME_HI_OFS) begin
			return SEL_HI;
		end
		return SEL_BAD;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("ERR %s expected 0x%08h actual 0x%08h at %0t", name, exp, act, $time);
		err_cnt++;
	endtask

	task automatic report_problem(input string msg);
		$display("error at %0t: %s", $time, msg);
		err_cnt++;
	endtask

	initial begin
		mtime_m   = `CLINT_MTIME_INIT;
		hi_m      = 32'd0;
		addr_full = 1'b0;
		addr_sel  = SEL_OUT;
		slot_full = 1'b0;
		rst_edge  = 1'b0;
		hold      = 1'b0;
		hold_data = 32'd0;
		hold_resp = 2'd0;
		err_cnt   = 0;
		beat_cnt  = 0;
		inflight  = 0;
	end

	always @(negedge clock_i) begin : step
		logic        drain;
		logic        slot_ready;
		logic        load;
		logic [31:0] data_e;
		logic [1:0]  resp_e;

		// both outputs quiet after a reset edge
		if (rst_edge && (addr_ready_i !== 1'b0 || r_valid_i !== 1'b0)) begin
			report_problem("addr_r_ready_o or r_valid_o is high after a reset edge");
		end
		if (r_valid_i !== 1'b1 && r_data_i !== 32'd0) begin
			report_mismatch("r_data_o", 32'd0, r_data_i);
		end
		// a stalled beat must not change
		if (hold) begin
			if (r_valid_i !== 1'b1) begin
				report_problem("r_valid_o fell before the response was accepted");
			end else begin
				if (r_data_i !== hold_data) begin
					report_mismatch("r_data_o", hold_data, r_data_i);
				end
				if (r_resp_i !== hold_resp) begin
					report_mismatch("r_resp_o", {30'd0, hold_resp}, {30'd0, r_resp_i});
				end
			end
		end

		if (rstn_i) begin
			mtime_m   = `CLINT_MTIME_INIT;
			hi_m      = 32'd0;
			addr_full = 1'b0;
			slot_full = 1'b0;
			hold      = 1'b0;
			inflight  = 0;
			exp_data_q.delete();
			exp_resp_q.delete();
		end else begin
			drain = r_valid_i & r_ready_i;
			if (drain) begin
				if (exp_data_q.size() == 0) begin
					report_problem("response beat with no read outstanding");
				end else begin
					data_e = exp_data_q.pop_front();
					resp_e = exp_resp_q.pop_front();
					if (r_data_i !== data_e) begin
						report_mismatch("r_data_o", data_e, r_data_i);
					end
					if (r_resp_i !== resp_e) begin
						report_mismatch("r_resp_o", {30'd0, resp_e}, {30'd0, r_resp_i});
					end
					beat_cnt++;
					inflight--;
				end
			end

			// request moves on when the slot is empty or drains now
			slot_ready = !slot_full || drain;
			load = addr_full && slot_ready;
			if (load) begin
				case (addr_sel)
					SEL_LO: begin
						data_e = mtime_m[31:0];
						resp_e = OKAY;
						hi_m   = mtime_m[63:32];
					end
					SEL_HI: begin
						data_e = hi_m;
						resp_e = OKAY;
					end
					SEL_BAD: begin
						data_e = 32'd0;
						resp_e = SLVERR;
					end
					default: begin
						data_e = 32'd0;
						resp_e = DECERR;
					end
				endcase
				exp_data_q.push_back(data_e);
				exp_resp_q.push_back(resp_e);
				slot_full = 1'b1;
			end else if (drain) begin
				slot_full = 1'b0;
			end

			if (addr_valid_i && addr_ready_i) begin
				addr_full = 1'b1;
				addr_sel  = decode_addr(addr_i);
				inflight++;
				if (inflight > 2) begin
					report_problem("more than two reads accepted ahead of their responses");
				end
			end else if (slot_ready) begin
				addr_full = 1'b0;
			end

			hold      = r_valid_i & ~r_ready_i;
			hold_data = r_data_i;
			hold_resp = r_resp_i;
			mtime_m   = mtime_m + 64'd1;
		end
		rst_edge = rstn_i;
	end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// 20 ns clock, rstn held high over the first two rising edges
// rst_req_i adds a reset later in the run, driven after a rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	input  wire logic rst_req_i,
	output logic      clock_o,
	output logic      rstn_o
);

	logic por_q;

	initial begin
		clock_o = 1'b0;
		forever #10 clock_o = ~clock_o;
	end

	// power-on reset for two cycles
	initial begin
		por_q = 1'b1;
		repeat (2) @(posedge clock_o);
		#1 por_q = 1'b0;
	end

	assign rstn_o = por_q | rst_req_i;

endmodule

`default_nettype wire

// File: design/clint_top.sv
// read-only CLINT mtime block; writes, bursts and strobes are not supported
// at most two reads are in flight, one per pipeline stage
`timescale 1ns/1ps
`default_nettype none

module clint_top
	import clint_pkg::*;
(
	input  wire logic        clock_i,
	input  wire logic        rstn_i,

	// address channel
	input  wire logic [31:0] addr_r_addr_i,
	input  wire logic        addr_r_valid_i,
	output logic             addr_r_ready_o,

	// read-data channel
	output logic      [31:0] r_data_o,
	output logic      [1:0]  r_resp_o,
	output logic             r_valid_o,
	input  wire logic        r_ready_i
);

	logic        req_valid;
	logic        req_ready;
	clint_sel_e  req_sel;
	logic        take_lo;
	logic [31:0] mtime_lo;
	logic [31:0] hi_latched;

	clint_timer u_timer (
		.clock_i      (clock_i),
		.rstn_i       (rstn_i),
		.take_lo_i    (take_lo),
		.mtime_lo_o   (mtime_lo),
		.hi_latched_o (hi_latched)
	);

	clint_addr_stage u_addr_stage (
		.clock_i      (clock_i),
		.rstn_i       (rstn_i),
		.addr_i       (addr_r_addr_i),
		.addr_valid_i (addr_r_valid_i),
		.addr_ready_o (addr_r_ready_o),
		.req_valid_o  (req_valid),
		.req_sel_o    (req_sel),
		.req_ready_i  (req_ready)
	);

	// high reads use the latched word, so the timer needs no take_hi
	clint_read_stage u_read_stage (
		.clock_i      (clock_i),
		.rstn_i       (rstn_i),
		.req_valid_i  (req_valid),
		.req_sel_i    (req_sel),
		.req_ready_o  (req_ready),
		.take_lo_o    (take_lo),
		.take_hi_o    (),
		.mtime_lo_i   (mtime_lo),
		.hi_latched_i (hi_latched),
		.r_data_o     (r_data_o),
		.r_resp_o     (r_resp_o),
		.r_valid_o    (r_valid_o),
		.r_ready_i    (r_ready_i)
	);

endmodule

`default_nettype wire

// File: design/clint_read_stage.sv
// response slot with optional delay; r_valid_o rises 1 + W cycles after a load
// data reads as zero whenever r_valid_o is low
`timescale 1ns/1ps
`default_nettype none

`include "clint_cfg.svh"

module clint_read_stage
	import clint_pkg::*;
(
	input  wire logic        clock_i,
	input  wire logic        rstn_i,

	// decoded request from the address stage
	input  wire logic        req_valid_i,
	input  wire clint_sel_e  req_sel_i,
	output logic             req_ready_o,

	// timer access
	output logic             take_lo_o,
	output logic             take_hi_o,
	input  wire logic [31:0] mtime_lo_i,
	input  wire logic [31:0] hi_latched_i,

	// read-data channel
	output logic      [31:0] r_data_o,
	output logic      [1:0]  r_resp_o,
	output logic             r_valid_o,
	input  wire logic        r_ready_i
);

	logic        full_q;
	logic [3:0]  wait_q;
	logic [3:0]  wait_cnt;
	logic        load;
	logic [31:0] data_d;
	logic [31:0] data_q;
	clint_resp_e resp_d;
	clint_resp_e resp_q;

	// wait count source depends on the delay mode
	generate
		if (`CLINT_DELAY_MODE == 2) begin : g_rand_delay
			clint_delay_lfsr u_lfsr (
				.clock_i (clock_i),
				.rstn_i  (rstn_i),
				.next_i  (load),
				.count_o (wait_cnt)
			);
		end else if (`CLINT_DELAY_MODE == 1) begin : g_fixed_delay
			assign wait_cnt = `CLINT_FIXED_DELAY;
		end else begin : g_no_delay
			assign wait_cnt = 4'd0;
		end
	endgenerate

	assign r_valid_o   = full_q & (wait_q == 4'd0);
	// slot empty, or it drains on this edge
	assign req_ready_o = ~full_q | (r_valid_o & r_ready_i);
	assign load        = req_valid_i & req_ready_o;

	assign take_lo_o = load & (req_sel_i == SEL_LO);
	assign take_hi_o = load & (req_sel_i == SEL_HI);

	// errors carry zero data
	always_comb begin
		case (req_sel_i)
			SEL_LO: begin
				data_d = mtime_lo_i;
				resp_d = OKAY;
			end
			SEL_HI: begin
				data_d = hi_latched_i;
				resp_d = OKAY;
			end
			SEL_BAD: begin
				data_d = 32'd0;
				resp_d = SLVERR;
			end
			default: begin
				data_d = 32'd0;
				resp_d = DECERR;
			end
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (rstn_i) begin
			full_q <= 1'b0;
			wait_q <= 4'd0;
		end else if (load) begin
			full_q <= 1'b1;
			wait_q <= wait_cnt;
		end else begin
			if (r_valid_o & r_ready_i) begin
				full_q <= 1'b0;
			end
			// count down only while a response waits
			if (full_q && wait_q != 4'd0) begin
				wait_q <= wait_q - 4'd1;
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (load) begin
			data_q <= data_d;
			resp_q <= resp_d;
		end
	end

	assign r_data_o = r_valid_o ? data_q : 32'd0;
	assign r_resp_o = resp_q;

endmodule

`default_nettype wire

// File: design/clint_delay_lfsr.sv
// 4-bit Fibonacci LFSR, taps x^4 + x^3 + 1, period 15
// steps only on next_i so the wait sequence is fixed per seed
`timescale 1ns/1ps
`default_nettype none

`include "clint_cfg.svh"

module clint_delay_lfsr (
	input  wire logic       clock_i,
	input  wire logic       rstn_i,
	input  wire logic       next_i,
	output logic      [3:0] count_o
);

	logic [3:0] lfsr_q;
	logic       feedback;

	assign feedback = lfsr_q[3] ^ lfsr_q[2];

	always_ff @(posedge clock_i) begin
		if (rstn_i) begin
			lfsr_q <= `CLINT_LFSR_SEED;
		end else if (next_i) begin
			lfsr_q <= {lfsr_q[2:0], feedback};
		end
	end

	// current state is the wait count for the request being loaded
	assign count_o = lfsr_q;

endmodule

`default_nettype wire

// File: design/clint_addr_stage.sv
// one-entry address register with decode; only the 16-bit offset is compared
// inside the window, so unaligned offsets land in SEL_BAD
`timescale 1ns/1ps
`default_nettype none

`include "clint_cfg.svh"

module clint_addr_stage
	import clint_pkg::*;
(
	input  wire logic        clock_i,
	input  wire logic        rstn_i,

	// address channel from the bus master
	input  wire logic [31:0] addr_i,
	input  wire logic        addr_valid_i,
	output logic             addr_ready_o,

	// decoded request towards the read stage
	output logic             req_valid_o,
	output clint_sel_e       req_sel_o,
	input  wire logic        req_ready_i
);

	localparam logic [31:0] WIN_BASE = `CLINT_BASE;

	logic       run_q;
	logic       valid_q;
	logic       accept;
	clint_sel_e sel_d;
	clint_sel_e sel_q;

	// slot free, or its entry leaves this cycle
	assign addr_ready_o = run_q & (~valid_q | req_ready_i);
	assign accept       = addr_valid_i & addr_ready_o;

	// window check on the upper half, then the word offset
	always_comb begin
		if (addr_i[31:16] != WIN_BASE[31:16]) begin
			sel_d = SEL_OUT;
		end else if (addr_i[15:0] == `CLINT_MTIME_LO_OFS) begin
			sel_d = SEL_LO;
		end else if (addr_i[15:0] == `CLINT_MTIME_HI_OFS) begin
			sel_d = SEL_HI;
		end else begin
			sel_d = SEL_BAD;
		end
	end

	// run_q keeps ready low through the reset cycles
	always_ff @(posedge clock_i) begin
		if (rstn_i) begin
			run_q   <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
			if (accept) begin
				valid_q <= 1'b1;
			end else if (req_ready_i) begin
				valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (accept) begin
			sel_q <= sel_d;
		end
	end

	assign req_valid_o = valid_q;
	assign req_sel_o   = sel_q;

endmodule

`default_nettype wire

// File: design/clint_timer.sv
// 64-bit mtime, held at the start value during reset, free running after
// the high half is latched on a low read so that hi reads pair with it
`timescale 1ns/1ps
`default_nettype none

`include "clint_cfg.svh"

module clint_timer
	import clint_pkg::*;
(
	input  wire logic        clock_i,
	input  wire logic        rstn_i,

	// pulse when a low read enters the read stage
	input  wire logic        take_lo_i,

	output logic      [31:0] mtime_lo_o,
	output logic      [31:0] hi_latched_o
);

	mtime_word_u mtime_q;
	logic [31:0] hi_latched_q;

	// counter adds on the whole 64-bit view
	always_ff @(posedge clock_i) begin
		if (rstn_i) begin
			mtime_q.full <= `CLINT_MTIME_INIT;
		end else begin
			mtime_q.full <= mtime_q.full + 64'd1;
		end
	end

	// snapshot of the high word taken with each low read
	always_ff @(posedge clock_i) begin
		if (rstn_i) begin
			hi_latched_q <= 32'd0;
		end else if (take_lo_i) begin
			hi_latched_q <= mtime_q.half.hi;
		end
	end

	// read path takes words from the half view
	assign mtime_lo_o   = mtime_q.half.lo;
	assign hi_latched_o = hi_latched_q;

endmodule

`default_nettype wire

// File: design/clint_pkg.sv
// shared types of the CLINT timer; response codes follow the AXI encoding
`default_nettype none

package clint_pkg;

	// read response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} clint_resp_e;

	// decoded register select
	typedef enum logic [1:0] {
		SEL_LO  = 2'd0,
		SEL_HI  = 2'd1,
		SEL_BAD = 2'd2,
		SEL_OUT = 2'd3
	} clint_sel_e;

	// mtime seen as one counter or as two bus words
	typedef union packed {
		logic [63:0] full;
		struct packed {
			logic [31:0] hi;
			logic [31:0] lo;
		} half;
	} mtime_word_u;

endpackage

`default_nettype wire

// File: design/clint_cfg.svh
// build-time settings for the CLINT timer; the window must be 64 KiB aligned
// delay mode 0 none, 1 fixed, 2 random from the 4-bit LFSR
`ifndef CLINT_CFG_SVH
`define CLINT_CFG_SVH

// base of the 64 KiB CLINT window
`define CLINT_BASE 32'h0200_0000

// word offsets of mtime inside the window
`define CLINT_MTIME_LO_OFS 16'hbff8
`define CLINT_MTIME_HI_OFS 16'hbffc

// start value just below a 32-bit carry
`define CLINT_MTIME_INIT 64'h0000_0000_ffff_ff00

// response delay selection
`define CLINT_DELAY_MODE 2'd2
`define CLINT_FIXED_DELAY 4'd3

// must be nonzero or the LFSR locks up
`define CLINT_LFSR_SEED 4'b1001

`endif
